// File: design/byte_ram.sv
`timescale 1ns/1ps
`default_nettype none

module byte_ram #(
  parameter int MEM_ADDR_W = 10
) (
  input  logic   clk,
  input  logic   csn,
  mem_bus_if.mem bus
);
  import spi_bridge_pkg::*;

  localparam int DEPTH = 1 << MEM_ADDR_W;

  byte_t                  mem [DEPTH];  // byte storage
  logic [MEM_ADDR_W-1:0]  ram_addr;     // upper address bits ignored

  assign ram_addr = bus.addr[MEM_ADDR_W-1:0];

  always_ff @(posedge clk)
  begin
    if (bus.wr)
      mem[ram_addr] <= bus.wdata;
  end

  // read data registered, held until the next rd
  always_ff @(posedge clk or posedge csn)
  begin
    if (csn)
      bus.rdata <= '0;
    else if (bus.rd)
      bus.rdata <= mem[ram_addr];
  end

endmodule

`default_nettype wire

// File: design/mem_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if;
  import spi_bridge_pkg::*;

  logic      rd;                // one-clk read strobe
  logic      wr;                // one-clk write strobe
  spi_addr_t addr;              // already masked to RAM range
  byte_t     wdata;             // byte assembled from mosi
  byte_t     rdata;             // registered RAM output, held until next rd

  // frame FSM side
  modport ctrl (output rd, output wr, output addr);

  // shift register side
  modport data (output wdata, input rdata);

  // RAM side
  modport mem (input rd, input wr, input addr, input wdata, output rdata);

endinterface

`default_nettype wire

// File: design/spi_bit_timer.sv
`timescale 1ns/1ps
`default_nettype none

module spi_bit_timer (
  input  logic clk,
  input  logic csn,
  input  logic sclk,
  input  logic mosi,
  input  logic spi_sel_n,
  output logic sel,
  output logic rise_pulse,
  output logic mosi_bit,
  output logic byte_done
);

  logic [1:0] sclk_sync;        // two-flop synchronizer for sclk
  logic [1:0] mosi_sync;        // same for mosi
  logic [1:0] sel_n_sync;       // same for the select pin, still active low
  logic       sclk_prev;        // last synchronized sclk level
  logic [2:0] bit_cnt;          // bits already taken in current byte
  logic       sclk_rise;        // rising edge seen this clk

  // pins into clk domain
  always_ff @(posedge clk or posedge csn)
  begin
    if (csn)
    begin
      sclk_sync  <= 2'b00;
      mosi_sync  <= 2'b00;
      sel_n_sync <= 2'b11;      // deselected out of reset
    end
    else
    begin
      sclk_sync  <= {sclk_sync[0], sclk};
      mosi_sync  <= {mosi_sync[0], mosi};
      sel_n_sync <= {sel_n_sync[0], spi_sel_n};
    end
  end

  assign sel       = ~sel_n_sync[1];                  // active high select
  assign mosi_bit  = mosi_sync[1];                    // stable around the sclk rise
  assign sclk_rise = sclk_sync[1] & ~sclk_prev & sel; // mode 0 sample edge

  // edge detect and bit count
  always_ff @(posedge clk or posedge csn)
  begin
    if (csn)
    begin
      sclk_prev  <= 1'b0;
      rise_pulse <= 1'b0;
      byte_done  <= 1'b0;
      bit_cnt    <= 3'd0;
    end
    else
    begin
      sclk_prev  <= sclk_sync[1];
      rise_pulse <= sclk_rise;                          // 3 clk after pin edge
      byte_done  <= sclk_rise && (bit_cnt == 3'd7);     // 8th bit of byte
      if (!sel)
        bit_cnt <= 3'd0;                                // partial byte dropped
      else if (sclk_rise)
        bit_cnt <= bit_cnt + 3'd1;                      // wraps to 0 after bit 8
    end
  end

endmodule

`default_nettype wire

// File: design/spi_bram_top.sv
`timescale 1ns/1ps
`default_nettype none

module spi_bram_top #(
  parameter int MEM_ADDR_W = 10
) (
  input  logic clk,
  input  logic csn,
  input  logic sclk,
  input  logic mosi,
  input  logic spi_sel_n,
  output logic miso,
  output logic miso_en
);
  import spi_bridge_pkg::*;

  logic  sel;                   // synchronized select, active high
  logic  rise_pulse;            // one clk per sclk rise
  logic  mosi_bit;
  logic  byte_done;             // 8th bit of a byte
  logic  load;                  // rdata into shift register
  byte_t shift_byte;            // received byte to FSM

  mem_bus_if bus ();            // FSM, shift register and RAM

  spi_bit_timer u_spi_bit_timer (
    .clk        (clk),
    .csn        (csn),
    .sclk       (sclk),
    .mosi       (mosi),
    .spi_sel_n  (spi_sel_n),
    .sel        (sel),
    .rise_pulse (rise_pulse),
    .mosi_bit   (mosi_bit),
    .byte_done  (byte_done)
  );

  spi_frame_fsm #(
    .MEM_ADDR_W (MEM_ADDR_W)
  ) u_spi_frame_fsm (
    .clk        (clk),
    .csn        (csn),
    .sel        (sel),
    .byte_done  (byte_done),
    .shift_byte (shift_byte),
    .load       (load),
    .bus        (bus.ctrl)
  );

  spi_shift_reg u_spi_shift_reg (
    .clk        (clk),
    .csn        (csn),
    .sel        (sel),
    .rise_pulse (rise_pulse),
    .mosi_bit   (mosi_bit),
    .load       (load),
    .shift_byte (shift_byte),
    .miso       (miso),
    .bus        (bus.data)
  );

  byte_ram #(
    .MEM_ADDR_W (MEM_ADDR_W)
  ) u_byte_ram (
    .clk        (clk),
    .csn        (csn),
    .bus        (bus.mem)
  );

  assign miso_en = sel;         // drive miso only while selected

endmodule

`default_nettype wire

// File: design/spi_bridge_pkg.sv
`default_nettype none

package spi_bridge_pkg;

  // one byte on the SPI wire or in the RAM
  typedef logic [7:0] byte_t;

  // full 16-bit frame address, the RAM uses only its low bits
  typedef logic [15:0] spi_addr_t;

  // first byte of every frame
  typedef enum logic [7:0] {
    CMD_WRITE = 8'h00,          // data bytes follow the address
    CMD_READ  = 8'h01           // dummy byte, then slave returns data
  } cmd_e;

  // where the slave is inside a frame
  typedef enum logic [2:0] {
    ST_IDLE    = 3'd0,          // spi_sel_n high
    ST_CMD     = 3'd1,          // collecting command byte
    ST_ADDR_HI = 3'd2,          // address bits 15..8
    ST_ADDR_LO = 3'd3,          // address bits 7..0
    ST_DUMMY   = 3'd4,          // read turnaround byte
    ST_WRITE   = 3'd5,          // data bytes into RAM
    ST_READ    = 3'd6,          // data bytes out of RAM
    ST_IGNORE  = 3'd7           // unknown command, drop the rest
  } frame_phase_e;

endpackage

`default_nettype wire

// File: design/spi_frame_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module spi_frame_fsm #(
  parameter int MEM_ADDR_W = 10
) (
  input  logic                  clk,
  input  logic                  csn,
  input  logic                  sel,
  input  logic                  byte_done,
  input  spi_bridge_pkg::byte_t shift_byte,
  output logic                  load,
  mem_bus_if.ctrl               bus
);
  import spi_bridge_pkg::*;

  // keeps only the address bits the RAM decodes
  localparam spi_addr_t ADDR_MASK = spi_addr_t'((17'd1 << MEM_ADDR_W) - 17'd1);

  frame_phase_e phase;          // current frame phase
  frame_phase_e phase_nxt;
  cmd_e         cmd_q;          // latched command byte
  spi_addr_t    addr_q;         // running frame address
  spi_addr_t    addr_cur;       // address presented this clk
  logic         cmd_ok;         // command byte is one we know
  logic         rd_now;         // first read of a read frame
  logic         rd_pend;        // prefetch after each load
  logic         wr_now;
  logic         load_now;

  assign cmd_ok = (shift_byte == CMD_WRITE) || (shift_byte == CMD_READ);

  // low address byte goes straight out for the first read
  assign addr_cur = (phase == ST_ADDR_LO) ? {addr_q[15:8], shift_byte} : addr_q;

  always_comb
  begin
    phase_nxt = phase;
    rd_now    = 1'b0;
    wr_now    = 1'b0;
    load_now  = 1'b0;
    if (!sel)
      phase_nxt = ST_IDLE;                      // frame closed or not started
    else
    begin
      case (phase)
        ST_IDLE:
          phase_nxt = ST_CMD;
        ST_CMD:
          if (byte_done)
            phase_nxt = cmd_ok ? ST_ADDR_HI : ST_IGNORE;
        ST_ADDR_HI:
          if (byte_done)
            phase_nxt = ST_ADDR_LO;
        ST_ADDR_LO:
          if (byte_done)
          begin
            if (cmd_q == CMD_READ)
            begin
              rd_now    = 1'b1;                 // fetch first byte during dummy
              phase_nxt = ST_DUMMY;
            end
            else
              phase_nxt = ST_WRITE;
          end
        ST_DUMMY:
          if (byte_done)
          begin
            load_now  = 1'b1;                   // first returned byte
            phase_nxt = ST_READ;
          end
        ST_READ:
          load_now = byte_done;                 // next returned byte
        ST_WRITE:
          wr_now = byte_done;                   // completed byte to RAM
        default: ;                              // ST_IGNORE waits for deselect
      endcase
    end
  end

  always_ff @(posedge clk or posedge csn)
  begin
    if (csn)
    begin
      phase   <= ST_IDLE;
      cmd_q   <= CMD_WRITE;
      addr_q  <= '0;
      rd_pend <= 1'b0;
    end
    else
    begin
      phase   <= phase_nxt;
      rd_pend <= load_now;                      // read ahead one clk after load
      if (sel && byte_done)
      begin
        case (phase)
          ST_CMD:     cmd_q         <= cmd_e'(shift_byte);
          ST_ADDR_HI: addr_q[15:8]  <= shift_byte;
          ST_ADDR_LO: addr_q[7:0]   <= shift_byte;
          ST_DUMMY,
          ST_READ,
          ST_WRITE:   addr_q        <= addr_q + 16'd1;  // wraps in RAM via mask
          default: ;
        endcase
      end
    end
  end

  assign load     = load_now;
  assign bus.rd   = rd_now | rd_pend;
  assign bus.wr   = wr_now;
  assign bus.addr = addr_cur & ADDR_MASK;

endmodule

`default_nettype wire

// File: design/spi_shift_reg.sv
`timescale 1ns/1ps
`default_nettype none

module spi_shift_reg (
  input  logic                  clk,
  input  logic                  csn,
  input  logic                  sel,
  input  logic                  rise_pulse,
  input  logic                  mosi_bit,
  input  logic                  load,
  output spi_bridge_pkg::byte_t shift_byte,
  output logic                  miso,
  mem_bus_if.data               bus
);
  import spi_bridge_pkg::*;

  byte_t sr;                    // shift register, MSB goes out first
  byte_t full_byte;             // content plus the bit arriving now

  // with byte_done this is the whole received byte
  assign full_byte = {sr[6:0], mosi_bit};

  always_ff @(posedge clk or posedge csn)
  begin
    if (csn)
      sr <= '0;
    else if (!sel)
      sr <= '0;                 // miso starts each frame at 0
    else if (load)
      sr <= bus.rdata;          // read byte replaces the shift
    else if (rise_pulse)
      sr <= full_byte;          // mosi into LSB
  end

  assign shift_byte = full_byte;  // command and address to FSM
  assign bus.wdata  = full_byte;  // write data to RAM
  assign miso       = sr[7];

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# builds the SPI block RAM testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_spi_bram -Mdir obj_dir -o tb_spi_bram -f verilog.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_spi_bram 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1

// File: testbench/spi_patterns.txt
# op addr count bytes, op is W write, R read and compare, X unknown command, A aborted write
# addr and bytes in hex, count in decimal
W 0010 4 11 22 33 44
R 0010 4 11 22 33 44
W 0011 1 5c
R 0010 4 11 5c 33 44
# longer burst read back whole and in part
W 0020 8 a0 a1 a2 a3 a4 a5 a6 a7
R 0020 8 a0 a1 a2 a3 a4 a5 a6 a7
R 0023 3 a3 a4 a5
# burst across the top of the 1 KiB RAM
W 03fe 4 e1 e2 e3 e4
R 03fe 4 e1 e2 e3 e4
R 0000 2 e3 e4
# upper address bits are not decoded
R 0410 2 11 5c
R 07ff 2 e2 e3
# unknown command leaves memory alone
W 0100 6 01 02 03 04 05 06
X 0100 3 ee ee ee
R 0100 6 01 02 03 04 05 06
# aborted frame keeps only its whole bytes
W 0200 4 55 66 77 88
A 0200 2 99 aa
R 0200 4 99 aa 77 88
# single byte frames at both ends of memory
W 0000 1 0f
W 03ff 1 f0
R 03ff 2 f0 0f
R 0020 1 a0

// File: testbench/tb_spi_bram.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_bram;
  import spi_bridge_pkg::*;

  localparam int    MEM_ADDR_W = 10;
  localparam byte_t BAD_CMD    = 8'h5a;   // neither write nor read

  logic clk = 1'b0;
  logic csn;
  logic sclk;
  logic mosi;
  logic spi_sel_n;
  logic miso;
  logic miso_en;

  logic [7:0]  op_q[$];                 // frame kind per pattern line
  spi_addr_t   frame_addr_q[$];         // frame address as sent
  int          cnt_q[$];                // data bytes in the frame
  int          start_q[$];              // first entry in data_q
  byte_t       data_q[$];               // all data bytes in file order
  logic [15:0] lfsr = 16'd43092;        // sclk level jitter
  int          total_bytes = 0;         // bytes on the wire, all frames
  int          cycle_cnt = 0;
  int          cycle_limit = 0;         // 0 until patterns are read

  spi_bram_top #(
    .MEM_ADDR_W (MEM_ADDR_W)
  ) u_spi_bram_top (
    .clk       (clk),
    .csn       (csn),
    .sclk      (sclk),
    .mosi      (mosi),
    .spi_sel_n (spi_sel_n),
    .miso      (miso),
    .miso_en   (miso_en)
  );

  always #4 clk = ~clk;                 // 8 ns period

  // run length guard
  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit)
    begin
      $display("timeout after %0d clk cycles with frames still running", cycle_cnt);
      $display("Simulation failed");
      $fatal(1, "cycle limit reached");
    end
  end

  task stop_with_error(input string why);
    $display("ERROR: %s", why);
    $display("Simulation failed");
    $fatal(1, "%s", why);
  endtask

  task check_byte(input string name, input byte_t exp, input byte_t act);
    if (act !== exp)
    begin
      $display("FAILED at %t: %s expected 0x%h, got 0x%h", $time, name, exp, act);
      $display("Simulation failed");
      $fatal(1, "byte mismatch on %s", name);
    end
  endtask

  task check_level(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("FAILED at %t: %s expected %b, got %b", $time, name, exp, act);
      $display("Simulation failed");
      $fatal(1, "level mismatch on %s", name);
    end
  endtask

  function logic lfsr_step();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out)
      lfsr = lfsr ^ 16'hb400;           // taps 16 14 13 11
    return out;
  endfunction

  // one sclk level, 4 to 7 clk
  function int level_len();
    logic b1;
    logic b0;
    b1 = lfsr_step();
    b0 = lfsr_step();
    return 4 + int'({b1, b0});
  endfunction

  // header is 3 bytes; reads add a dummy byte and aborts a partial one
  function int frame_bytes(input logic [7:0] op, input int cnt);
    if (op == "R" || op == "A")
      return cnt + 4;
    return cnt + 3;
  endfunction

  task wait_clks(input int n);
    repeat (n) @(negedge clk);
  endtask

  // mode 0, MSB first, nbits from bit 7 down
  task xfer_bits(input byte_t tx, input int nbits, output byte_t rx);
    int i;
    rx = '0;
    for (i = 7; i > 7 - nbits; i--)
    begin
      mosi = tx[i];                     // changes while sclk is low
      wait_clks(level_len());
      rx[i] = miso;                     // falling clk edge before the rise
      sclk = 1'b1;
      wait_clks(level_len());
      sclk = 1'b0;
    end
  endtask

  task send_header(input byte_t cmd, input spi_addr_t addr);
    byte_t rx;
    xfer_bits(cmd, 8, rx);
    xfer_bits(addr[15:8], 8, rx);
    xfer_bits(addr[7:0], 8, rx);
  endtask

  task frame_begin();
    spi_sel_n = 1'b0;
    wait_clks(4);                       // select through the synchronizer
    check_level("miso_en", 1'b1, miso_en);
    check_level("miso", 1'b0, miso);    // shift register cleared between frames
  endtask

  task frame_end();
    wait_clks(2);
    spi_sel_n = 1'b1;
    wait_clks(6);                       // bit counter and FSM back to idle
    check_level("miso_en", 1'b0, miso_en);
    check_level("miso", 1'b0, miso);
  endtask

  task run_frame(input int n);
    byte_t rx;
    int    k;
    frame_begin();
    case (op_q[n])
      "W", "A": send_header(CMD_WRITE, frame_addr_q[n]);
      "R":      send_header(CMD_READ, frame_addr_q[n]);
      default:  send_header(BAD_CMD, frame_addr_q[n]);
    endcase
    if (op_q[n] == "R")
      xfer_bits(8'h00, 8, rx);          // dummy byte while RAM is read
    for (k = 0; k < cnt_q[n]; k++)
    begin
      if (op_q[n] == "R")
      begin
        xfer_bits(8'h00, 8, rx);
        check_byte($sformatf("miso byte %0d of read at 0x%h", k, frame_addr_q[n]),
                   data_q[start_q[n] + k], rx);
      end
      else
        xfer_bits(data_q[start_q[n] + k], 8, rx);
    end
    if (op_q[n] == "A")
      xfer_bits(8'hc3, 4, rx);          // half a byte, then deselect
    frame_end();
  endtask

  task load_patterns();
    int         fd;
    int         c;
    int         code;
    int         k;
    int         cnt;
    logic [7:0] ch;
    spi_addr_t  addr;
    byte_t      b;
    fd = $fopen("testbench/spi_patterns.txt", "r");
    if (fd == 0)
      stop_with_error("cannot open testbench/spi_patterns.txt");
    c = $fgetc(fd);
    while (c != -1)
    begin
      ch = c[7:0];
      if (ch == "#")
      begin
        while (c != -1 && c[7:0] != "\n")   // comment runs to end of line
          c = $fgetc(fd);
      end
      else if (ch == "W" || ch == "R" || ch == "X" || ch == "A")
      begin
        code = $fscanf(fd, "%h %d", addr, cnt);
        if (code != 2)
          stop_with_error($sformatf("pattern line %s has no address or count", ch));
        op_q.push_back(ch);
        frame_addr_q.push_back(addr);
        cnt_q.push_back(cnt);
        start_q.push_back(data_q.size());
        for (k = 0; k < cnt; k++)
        begin
          code = $fscanf(fd, "%h", b);
          if (code != 1)
            stop_with_error("pattern line ends before its byte count");
          data_q.push_back(b);
        end
        total_bytes += frame_bytes(ch, cnt);
      end
      else if (ch != " " && ch != "\t" && ch != "\n" && ch != "\r")
        stop_with_error($sformatf("unknown operation %s in pattern file", ch));
      c = $fgetc(fd);
    end
    $fclose(fd);
    if (op_q.size() == 0)
      stop_with_error("pattern file holds no frames");
  endtask

  initial
  begin
    int n;
    $timeformat(-9, 0, " ns", 0);
    csn       = 1'b1;
    sclk      = 1'b0;
    mosi      = 1'b0;
    spi_sel_n = 1'b1;
    load_patterns();
    cycle_limit = total_bytes * 8 * 14 + 200;   // slowest sclk is 14 clk per bit
    wait_clks(3);                       // three rising edges in reset
    csn = 1'b0;
    wait_clks(2);
    check_level("miso_en", 1'b0, miso_en);
    check_level("miso", 1'b0, miso);
    for (n = 0; n < op_q.size(); n++)
      run_frame(n);
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
design/spi_bridge_pkg.sv
design/mem_bus_if.sv
design/spi_bit_timer.sv
design/spi_frame_fsm.sv
design/spi_shift_reg.sv
design/byte_ram.sv
design/spi_bram_top.sv
testbench/tb_spi_bram.sv
